// File: logic/rasterizer_cfg.svh
// Fixed sizes of the tile renderer, shared by the packages and the RTL.
// Include this file wherever one of the macros below is needed.
`ifndef RASTERIZER_CFG_SVH
`define RASTERIZER_CFG_SVH

// Tile dimensions in pixels
`define X_RESOLUTION 16
`define Y_RESOLUTION 16
`define FRAME_SIZE (`X_RESOLUTION * `Y_RESOLUTION)

// Pixel index into the tile memory
`define INDEX_WIDTH 8

// Command stream word
`define CMD_WIDTH 32

// Words that follow a triangle header
`define PARAM_WORDS 12

`endif

// File: logic/CommandPkg.sv
// Types of the command side: header opcodes, triangle parameter slots
// and the beat carried on the command stream.
`default_nettype none
`include "rasterizer_cfg.svh"

package CommandPkg;

    // Opcode sits in the top 4 bits of a header word
    typedef enum logic [3:0] {
        OP_NOP             = 4'h0,
        OP_SET_CLEAR_COLOR = 4'h1,
        OP_CLEAR           = 4'h2,
        OP_TRIANGLE        = 4'h3,
        OP_COMMIT          = 4'h4
    } cmdOpcode_t;

    // Parameter words in the order they follow OP_TRIANGLE
    typedef enum logic [3:0] {
        BB_START, BB_END,
        W0, W1, W2,
        W0_INC_X, W1_INC_X, W2_INC_X,
        W0_INC_Y, W1_INC_Y, W2_INC_Y,
        COLOR
    } paramSlot_t;

    typedef struct packed {
        logic [`CMD_WIDTH-1:0] data;
        logic                  last;
    } cmdBeat_t;

endpackage

`default_nettype wire

// File: logic/RasterPkg.sv
// Types of the pixel side: triangle setup, fragments from the rasterizer
// and the beat streamed out of the frame buffer on commit.
`default_nettype none
`include "rasterizer_cfg.svh"

package RasterPkg;

    // RGB565
    typedef logic [15:0] color_t;

    typedef logic [$clog2(`X_RESOLUTION)-1:0] xCoord_t;
    typedef logic [$clog2(`Y_RESOLUTION)-1:0] yCoord_t;

    // Bounding box is inclusive on both ends
    typedef struct packed {
        xCoord_t            bbStartX;
        yCoord_t            bbStartY;
        xCoord_t            bbEndX;
        yCoord_t            bbEndY;
        logic signed [31:0] w0;
        logic signed [31:0] w1;
        logic signed [31:0] w2;
        logic signed [31:0] w0IncX;
        logic signed [31:0] w1IncX;
        logic signed [31:0] w2IncX;
        logic signed [31:0] w0IncY;
        logic signed [31:0] w1IncY;
        logic signed [31:0] w2IncY;
        color_t             color;
    } triangleParams_t;

    typedef struct packed {
        logic [`INDEX_WIDTH-1:0] index;
        color_t                  color;
    } fragment_t;

    typedef struct packed {
        color_t color;
        logic   last;
    } pixelBeat_t;

endpackage

`default_nettype wire

// File: logic/CommandParser.sv
// Front end of the tile renderer. Decodes header words, forwards triangle
// parameters to the register bank and fires the start pulses of the units.
`timescale 1ns/1ps
`default_nettype none
`include "rasterizer_cfg.svh"

module CommandParser (
    input  wire                    aclk,
    input  wire                    rst,

    input  wire                    cmdValid,
    output logic                   cmdReady,
    input  wire CommandPkg::cmdBeat_t cmdBeat,

    output logic                   paramWrite,
    output CommandPkg::paramSlot_t paramSlot,
    output logic [31:0]            paramData,
    output logic                   clearColorWrite,
    output RasterPkg::color_t      clearColor,

    output logic                   startRendering,
    input  wire                    rasterizerRunning,
    output logic                   clearStart,
    output logic                   commitStart,
    input  wire                    frameBusy
);
    import CommandPkg::*;

    typedef enum logic [1:0] {IDLE, PARAMS, ISSUE} parserState_t;

    parserState_t state;
    cmdOpcode_t   opcode;
    cmdOpcode_t   issueOp;
    paramSlot_t   slot;
    logic         unitsIdle;
    logic         headerFire;

    assign opcode    = cmdOpcode_t'(cmdBeat.data[`CMD_WIDTH-1 -: 4]);
    assign unitsIdle = !rasterizerRunning && !frameBusy;

    // NOP headers pass even while a unit is busy
    always_comb begin
        cmdReady = 1'b0;
        if (state == PARAMS) begin
            cmdReady = 1'b1;
        end else if (state == IDLE) begin
            cmdReady = cmdValid && (unitsIdle || opcode == OP_NOP);
        end
    end

    assign headerFire = (state == IDLE) && cmdValid && cmdReady;

    // Register bank writes
    assign paramWrite      = (state == PARAMS) && cmdValid;
    assign paramSlot       = slot;
    assign paramData       = cmdBeat.data;
    assign clearColorWrite = headerFire && (opcode == OP_SET_CLEAR_COLOR);
    assign clearColor      = cmdBeat.data[15:0];

    // One cycle pulses out of ISSUE
    assign startRendering = (state == ISSUE) && (issueOp == OP_TRIANGLE);
    assign clearStart     = (state == ISSUE) && (issueOp == OP_CLEAR);
    assign commitStart    = (state == ISSUE) && (issueOp == OP_COMMIT);

    //////////////////////////////
    // Header and parameter FSM
    //////////////////////////////
    always_ff @(posedge aclk) begin
        if (rst) begin
            state   <= IDLE;
            issueOp <= OP_NOP;
            slot    <= BB_START;
        end else begin
            case (state)
                IDLE: begin
                    if (headerFire) begin
                        issueOp <= opcode;
                        slot    <= BB_START;
                        if (opcode == OP_TRIANGLE) begin
                            state <= PARAMS;
                        end else if (opcode == OP_CLEAR || opcode == OP_COMMIT) begin
                            state <= ISSUE;
                        end
                    end
                end
                PARAMS: begin
                    if (cmdValid) begin
                        if (slot == paramSlot_t'(`PARAM_WORDS - 1)) begin
                            state <= ISSUE;
                        end else begin
                            slot <= paramSlot_t'(slot + 1'b1);
                        end
                    end
                end
                ISSUE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // A new triangle must never overwrite one that is still rendering
    assert property (@(posedge aclk) disable iff (rst)
        startRendering |-> !rasterizerRunning)
        else $error("Triangle started while the rasterizer is running");

endmodule

`default_nettype wire

// File: logic/RegisterBank.sv
// Configuration registers of the tile renderer. Collects the triangle
// parameter words into one struct and holds the clear color.
`timescale 1ns/1ps
`default_nettype none
`include "rasterizer_cfg.svh"

module RegisterBank (
    input  wire                         aclk,
    input  wire                         rst,
    input  wire                         paramWrite,
    input  wire CommandPkg::paramSlot_t paramSlot,
    input  wire [`CMD_WIDTH-1:0]        paramData,
    input  wire                         clearColorWrite,
    input  wire RasterPkg::color_t      clearColorIn,
    output RasterPkg::triangleParams_t  triangleParams,
    output RasterPkg::color_t           clearColor
);
    import CommandPkg::*;
    import RasterPkg::*;

    // Box words carry x in the low half and y in the high half
    always_ff @(posedge aclk) begin
        if (paramWrite) begin
            case (paramSlot)
                BB_START: begin
                    triangleParams.bbStartX <= xCoord_t'(paramData[15:0]);
                    triangleParams.bbStartY <= yCoord_t'(paramData[31:16]);
                end
                BB_END: begin
                    triangleParams.bbEndX <= xCoord_t'(paramData[15:0]);
                    triangleParams.bbEndY <= yCoord_t'(paramData[31:16]);
                end
                W0:       triangleParams.w0     <= paramData;
                W1:       triangleParams.w1     <= paramData;
                W2:       triangleParams.w2     <= paramData;
                W0_INC_X: triangleParams.w0IncX <= paramData;
                W1_INC_X: triangleParams.w1IncX <= paramData;
                W2_INC_X: triangleParams.w2IncX <= paramData;
                W0_INC_Y: triangleParams.w0IncY <= paramData;
                W1_INC_Y: triangleParams.w1IncY <= paramData;
                W2_INC_Y: triangleParams.w2IncY <= paramData;
                COLOR:    triangleParams.color  <= paramData[15:0];
                default:  ;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            clearColor <= '0;
        end else if (clearColorWrite) begin
            clearColor <= clearColorIn;
        end
    end

endmodule

`default_nettype wire

// File: logic/Rasterizer.sv
// Edge function rasterizer. Walks the bounding box of one triangle row by
// row and emits a fragment for every pixel with all edge values >= 0.
`timescale 1ns/1ps
`default_nettype none
`include "rasterizer_cfg.svh"

module Rasterizer (
    input  wire                              aclk,
    input  wire                              rst,
    input  wire                              startRendering,
    output logic                             rasterizerRunning,
    input  wire RasterPkg::triangleParams_t  triangleParams,
    output logic                             fragValid,
    input  wire                              fragReady,
    output RasterPkg::fragment_t             frag
);
    import RasterPkg::*;

    typedef enum logic [1:0] {IDLE, WALK, DRAIN} rasterState_t;

    rasterState_t       state;
    xCoord_t            x;
    yCoord_t            y;
    logic signed [31:0] w0, w1, w2;
    logic signed [31:0] rowW0, rowW1, rowW2;
    logic               covered;
    logic               advance;
    logic               rowEnd;
    logic               boxEnd;

    assign covered = !w0[31] && !w1[31] && !w2[31];
    assign rowEnd  = (x == triangleParams.bbEndX);
    assign boxEnd  = rowEnd && (y == triangleParams.bbEndY);

    // Step only when the output register is free or drains this cycle
    assign advance = (state == WALK) && (!fragValid || fragReady);

    assign rasterizerRunning = (state != IDLE);

    //////////////////////////////
    // Walk control
    //////////////////////////////
    always_ff @(posedge aclk) begin
        if (rst) begin
            state     <= IDLE;
            fragValid <= 1'b0;
        end else begin
            if (fragReady) begin
                fragValid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (startRendering) begin
                        state <= WALK;
                    end
                end
                WALK: begin
                    if (advance) begin
                        fragValid <= covered;
                        if (boxEnd) begin
                            state <= DRAIN;
                        end
                    end
                end
                // Wait for the last fragment to leave
                DRAIN: begin
                    if (!fragValid || fragReady) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // Position and edge values
    //////////////////////////////
    always_ff @(posedge aclk) begin
        if (state == IDLE && startRendering) begin
            x     <= triangleParams.bbStartX;
            y     <= triangleParams.bbStartY;
            w0    <= triangleParams.w0;
            w1    <= triangleParams.w1;
            w2    <= triangleParams.w2;
            rowW0 <= triangleParams.w0;
            rowW1 <= triangleParams.w1;
            rowW2 <= triangleParams.w2;
        end else if (advance) begin
            // Row-major index is y * 16 + x
            frag.index <= {y, x};
            frag.color <= triangleParams.color;
            if (rowEnd) begin
                // Next row starts from the saved row start plus the y step
                x     <= triangleParams.bbStartX;
                y     <= y + 1'b1;
                rowW0 <= rowW0 + triangleParams.w0IncY;
                rowW1 <= rowW1 + triangleParams.w1IncY;
                rowW2 <= rowW2 + triangleParams.w2IncY;
                w0    <= rowW0 + triangleParams.w0IncY;
                w1    <= rowW1 + triangleParams.w1IncY;
                w2    <= rowW2 + triangleParams.w2IncY;
            end else begin
                x  <= x + 1'b1;
                w0 <= w0 + triangleParams.w0IncX;
                w1 <= w1 + triangleParams.w1IncX;
                w2 <= w2 + triangleParams.w2IncX;
            end
        end
    end

    // Fragments stay inside the bounding box of the triangle
    assert property (@(posedge aclk) disable iff (rst)
        fragValid |-> (frag.index[3:0] >= triangleParams.bbStartX &&
                       frag.index[3:0] <= triangleParams.bbEndX &&
                       frag.index[7:4] >= triangleParams.bbStartY &&
                       frag.index[7:4] <= triangleParams.bbEndY))
        else $error("Fragment outside the bounding box");

endmodule

`default_nettype wire

// File: logic/FrameBuffer.sv
// Tile color memory. Takes fragment writes while idle, fills itself with
// the clear color on a clear, and streams all pixels out on a commit.
`timescale 1ns/1ps
`default_nettype none
`include "rasterizer_cfg.svh"

module FrameBuffer (
    input  wire                        aclk,
    input  wire                        rst,
    input  wire                        fragValid,
    output logic                       fragReady,
    input  wire RasterPkg::fragment_t  frag,
    input  wire                        clearStart,
    input  wire                        commitStart,
    input  wire RasterPkg::color_t     clearColor,
    output logic                       frameBusy,
    output logic                       pixelValid,
    input  wire                        pixelReady,
    output RasterPkg::pixelBeat_t      pixelBeat
);
    import RasterPkg::*;

    typedef enum logic [1:0] {IDLE, CLEAR, COMMIT} fbMode_t;

    fbMode_t                mode;
    color_t                 mem [`FRAME_SIZE];
    // Extra bit marks the end of the read sweep
    logic [`INDEX_WIDTH:0]  addr;
    logic                   aheadValid;
    logic                   aheadLast;
    color_t                 aheadColor;
    logic                   moveAhead;
    logic                   readIssue;
    logic                   lastOut;

    assign frameBusy = (mode != IDLE);
    assign fragReady = !frameBusy;

    // Read-ahead entry moves into the output register when that one frees up
    assign moveAhead = aheadValid && (!pixelValid || pixelReady);
    assign readIssue = (mode == COMMIT) && !addr[`INDEX_WIDTH] && (!aheadValid || moveAhead);
    assign lastOut   = pixelValid && pixelReady && pixelBeat.last;

    //////////////////////////////
    // Mode and address
    //////////////////////////////
    always_ff @(posedge aclk) begin
        if (rst) begin
            mode <= IDLE;
            addr <= '0;
        end else begin
            case (mode)
                IDLE: begin
                    addr <= '0;
                    if (clearStart) begin
                        mode <= CLEAR;
                    end else if (commitStart) begin
                        mode <= COMMIT;
                    end
                end
                // One pixel per cycle for 256 cycles
                CLEAR: begin
                    addr <= addr + 1'b1;
                    if (addr == `FRAME_SIZE - 1) begin
                        mode <= IDLE;
                    end
                end
                COMMIT: begin
                    if (readIssue) begin
                        addr <= addr + 1'b1;
                    end
                    if (lastOut) begin
                        mode <= IDLE;
                    end
                end
                default: begin
                    mode <= IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // Tile memory
    //////////////////////////////
    always_ff @(posedge aclk) begin
        if (mode == CLEAR) begin
            mem[addr[`INDEX_WIDTH-1:0]] <= clearColor;
        end else if (fragValid && fragReady) begin
            mem[frag.index] <= frag.color;
        end
        if (readIssue) begin
            aheadColor <= mem[addr[`INDEX_WIDTH-1:0]];
            aheadLast  <= (addr == `FRAME_SIZE - 1);
        end
    end

    // Output stage
    always_ff @(posedge aclk) begin
        if (rst) begin
            aheadValid <= 1'b0;
            pixelValid <= 1'b0;
        end else begin
            if (readIssue) begin
                aheadValid <= 1'b1;
            end else if (moveAhead) begin
                aheadValid <= 1'b0;
            end
            if (moveAhead) begin
                pixelValid <= 1'b1;
            end else if (pixelReady) begin
                pixelValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (moveAhead) begin
            pixelBeat.color <= aheadColor;
            pixelBeat.last  <= aheadLast;
        end
    end

    assert property (@(posedge aclk) disable iff (rst)
        !(clearStart && commitStart))
        else $error("Clear and commit requested together");

endmodule

`default_nettype wire

// File: logic/TileRenderer.sv
// Top level of the tile renderer. Takes the command stream in and sends
// the committed 16x16 RGB565 tile out as a pixel stream.
`timescale 1ns/1ps
`default_nettype none

module TileRenderer (
    input  wire                       aclk,
    input  wire                       rst,
    input  wire                       cmdValid,
    output logic                      cmdReady,
    input  wire CommandPkg::cmdBeat_t cmdBeat,
    output logic                      pixelValid,
    input  wire                       pixelReady,
    output RasterPkg::pixelBeat_t     pixelBeat
);
    import CommandPkg::*;
    import RasterPkg::*;

    // Parser to register bank
    logic            paramWrite;
    paramSlot_t      paramSlot;
    logic [31:0]     paramData;
    logic            clearColorWrite;
    color_t          parserClearColor;

    // Register bank to units
    triangleParams_t triangleParams;
    color_t          clearColor;

    // Control
    logic            startRendering;
    logic            rasterizerRunning;
    logic            clearStart;
    logic            commitStart;
    logic            frameBusy;

    // Rasterizer to frame buffer
    logic            fragValid;
    logic            fragReady;
    fragment_t       frag;

    CommandParser u_CommandParser (
        .aclk(aclk),
        .rst(rst),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdBeat(cmdBeat),
        .paramWrite(paramWrite),
        .paramSlot(paramSlot),
        .paramData(paramData),
        .clearColorWrite(clearColorWrite),
        .clearColor(parserClearColor),
        .startRendering(startRendering),
        .rasterizerRunning(rasterizerRunning),
        .clearStart(clearStart),
        .commitStart(commitStart),
        .frameBusy(frameBusy)
    );

    RegisterBank u_RegisterBank (
        .aclk(aclk),
        .rst(rst),
        .paramWrite(paramWrite),
        .paramSlot(paramSlot),
        .paramData(paramData),
        .clearColorWrite(clearColorWrite),
        .clearColorIn(parserClearColor),
        .triangleParams(triangleParams),
        .clearColor(clearColor)
    );

    Rasterizer u_Rasterizer (
        .aclk(aclk),
        .rst(rst),
        .startRendering(startRendering),
        .rasterizerRunning(rasterizerRunning),
        .triangleParams(triangleParams),
        .fragValid(fragValid),
        .fragReady(fragReady),
        .frag(frag)
    );

    FrameBuffer u_FrameBuffer (
        .aclk(aclk),
        .rst(rst),
        .fragValid(fragValid),
        .fragReady(fragReady),
        .frag(frag),
        .clearStart(clearStart),
        .commitStart(commitStart),
        .clearColor(clearColor),
        .frameBusy(frameBusy),
        .pixelValid(pixelValid),
        .pixelReady(pixelReady),
        .pixelBeat(pixelBeat)
    );

endmodule

`default_nettype wire

// File: tests/TileRendererTb.sv
// Self-checking testbench for the tile renderer. Sends command streams,
// keeps a reference copy of the tile and checks every committed pixel.
`timescale 1ns/1ps
`default_nettype none
`include "rasterizer_cfg.svh"

module TileRendererTb;
    import CommandPkg::*;
    import RasterPkg::*;

    localparam logic [31:0] SEED = 32'h8707_9871;

    logic       aclk;
    logic       rst;
    logic       cmdValid;
    logic       cmdReady;
    cmdBeat_t   cmdBeat;
    logic       pixelValid;
    logic       pixelReady;
    pixelBeat_t pixelBeat;

    // Reference tile and the pixels expected from pending commits
    color_t      model [`FRAME_SIZE];
    color_t      expectQueue [$];
    color_t      refClearColor;
    string       testName;
    int          cmdCount;
    int          beatIndex;
    int          lastStall;
    int          headerStall;
    logic        randomReady;
    logic [31:0] rngState;
    logic [31:0] readyRng;

    TileRenderer u_TileRenderer (
        .aclk(aclk),
        .rst(rst),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdBeat(cmdBeat),
        .pixelValid(pixelValid),
        .pixelReady(pixelReady),
        .pixelBeat(pixelBeat)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        begin
            v = s;
            v = v ^ (v << 13);
            v = v ^ (v >> 17);
            v = v ^ (v << 5);
            xorshift = v;
        end
    endfunction

    // New color of one pixel after a triangle is drawn over it
    function automatic color_t shadePixel(input color_t current, input triangleParams_t t,
                                          input int px, input int py);
        int dx;
        int dy;
        int e0;
        int e1;
        int e2;
        begin
            shadePixel = current;
            if (px >= int'(t.bbStartX) && px <= int'(t.bbEndX) &&
                py >= int'(t.bbStartY) && py <= int'(t.bbEndY)) begin
                dx = px - int'(t.bbStartX);
                dy = py - int'(t.bbStartY);
                e0 = t.w0 + dx * t.w0IncX + dy * t.w0IncY;
                e1 = t.w1 + dx * t.w1IncX + dy * t.w1IncY;
                e2 = t.w2 + dx * t.w2IncX + dy * t.w2IncY;
                if (e0 >= 0 && e1 >= 0 && e2 >= 0) begin
                    shadePixel = t.color;
                end
            end
        end
    endfunction

    function automatic int smallSigned(input logic [31:0] r, input int span);
        smallSigned = int'(r % span) - span / 2;
    endfunction

    task checkEqual(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task nextRandom(output logic [31:0] value);
        rngState = xorshift(rngState);
        value = rngState;
    endtask

    task randomTriangle(output triangleParams_t t);
        logic [31:0] a;
        logic [31:0] b;
        begin
            nextRandom(a);
            nextRandom(b);
            t.bbStartX = (a[3:0] < b[3:0]) ? a[3:0] : b[3:0];
            t.bbEndX   = (a[3:0] < b[3:0]) ? b[3:0] : a[3:0];
            t.bbStartY = (a[7:4] < b[7:4]) ? a[7:4] : b[7:4];
            t.bbEndY   = (a[7:4] < b[7:4]) ? b[7:4] : a[7:4];
            nextRandom(a);
            t.w0 = smallSigned(a, 81);
            nextRandom(a);
            t.w1 = smallSigned(a, 81);
            nextRandom(a);
            t.w2 = smallSigned(a, 81);
            nextRandom(a);
            t.w0IncX = smallSigned(a, 17);
            nextRandom(a);
            t.w1IncX = smallSigned(a, 17);
            nextRandom(a);
            t.w2IncX = smallSigned(a, 17);
            nextRandom(a);
            t.w0IncY = smallSigned(a, 17);
            nextRandom(a);
            t.w1IncY = smallSigned(a, 17);
            nextRandom(a);
            t.w2IncY = smallSigned(a, 17);
            nextRandom(a);
            t.color = a[15:0];
        end
    endtask

    //////////////////////////////
    // Command drivers
    //////////////////////////////
    // Called on a falling edge, returns on the falling edge after the transfer
    task sendWord(input logic [31:0] data, input logic last);
        cmdBeat.data = data;
        cmdBeat.last = last;
        cmdValid = 1'b1;
        lastStall = 0;
        @(posedge aclk);
        while (!cmdReady) begin
            lastStall = lastStall + 1;
            @(posedge aclk);
        end
        @(negedge aclk);
        cmdValid = 1'b0;
    endtask

    task setClearColor(input color_t c);
        cmdCount = cmdCount + 1;
        refClearColor = c;
        sendWord({OP_SET_CLEAR_COLOR, 12'h000, c}, 1'b1);
    endtask

    task clearTile();
        int i;
        begin
            cmdCount = cmdCount + 1;
            for (i = 0; i < `FRAME_SIZE; i++) begin
                model[i] = refClearColor;
            end
            sendWord({OP_CLEAR, 28'h0}, 1'b1);
        end
    endtask

    task sendNop();
        cmdCount = cmdCount + 1;
        sendWord({OP_NOP, 28'h0}, 1'b1);
    endtask

    task commitTile();
        int i;
        begin
            cmdCount = cmdCount + 1;
            for (i = 0; i < `FRAME_SIZE; i++) begin
                expectQueue.push_back(model[i]);
            end
            sendWord({OP_COMMIT, 28'h0}, 1'b1);
        end
    endtask

    task drawTriangle(input triangleParams_t t);
        int i;
        begin
            cmdCount = cmdCount + 1;
            for (i = 0; i < `FRAME_SIZE; i++) begin
                model[i] = shadePixel(model[i], t, i % `X_RESOLUTION, i / `X_RESOLUTION);
            end
            sendWord({OP_TRIANGLE, 28'h0}, 1'b0);
            headerStall = lastStall;
            // Box words hold x in the low half and y in the high half
            sendWord({12'h000, t.bbStartY, 12'h000, t.bbStartX}, 1'b0);
            sendWord({12'h000, t.bbEndY, 12'h000, t.bbEndX}, 1'b0);
            sendWord(t.w0, 1'b0);
            sendWord(t.w1, 1'b0);
            sendWord(t.w2, 1'b0);
            sendWord(t.w0IncX, 1'b0);
            sendWord(t.w1IncX, 1'b0);
            sendWord(t.w2IncX, 1'b0);
            sendWord(t.w0IncY, 1'b0);
            sendWord(t.w1IncY, 1'b0);
            sendWord(t.w2IncY, 1'b0);
            sendWord({16'h0000, t.color}, 1'b1);
        end
    endtask

    task waitCommitsDone();
        while (expectQueue.size() != 0) begin
            @(negedge aclk);
        end
    endtask

    //////////////////////////////
    // Output side
    //////////////////////////////
    always @(negedge aclk) begin
        if (randomReady) begin
            readyRng = xorshift(readyRng);
            pixelReady = readyRng[0];
        end else begin
            pixelReady = 1'b1;
        end
    end

    always @(posedge aclk) begin : compareBeat
        color_t expected;
        if (!rst && pixelValid && pixelReady) begin
            if (expectQueue.size() == 0) begin
                $display("A pixel beat arrived while no commit was pending");
                $display("ERRORS FOUND");
                $fatal(1);
            end else begin
                expected = expectQueue.pop_front();
                checkEqual(testName, expected, pixelBeat.color);
                checkEqual({testName, " last flag"}, beatIndex == `FRAME_SIZE - 1,
                           pixelBeat.last);
                beatIndex = (beatIndex + 1) % `FRAME_SIZE;
            end
        end
    end

    // Budget grows with every command sent
    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge aclk);
            cycles = cycles + 1;
            if (cycles > 2000 * (cmdCount + 1)) begin
                $display("Timeout: the renderer stopped making progress");
                $display("ERRORS FOUND");
                $fatal(1);
            end
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin : stimulus
        triangleParams_t t1;
        triangleParams_t t2;
        logic [31:0]     r;
        rst = 1'b1;
        cmdValid = 1'b0;
        cmdBeat = '0;
        pixelReady = 1'b0;
        randomReady = 1'b0;
        rngState = SEED;
        readyRng = xorshift(SEED ^ 32'h5A5A_5A5A);
        refClearColor = '0;
        testName = "reset";
        cmdCount = 0;
        beatIndex = 0;
        headerStall = 0;
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;

        testName = "clear and commit";
        setClearColor(16'hA5C3);
        clearTile();
        commitTile();
        waitCommitsDone();

        testName = "random triangle";
        randomTriangle(t1);
        drawTriangle(t1);
        commitTile();
        waitCommitsDone();

        testName = "commit under back-pressure";
        randomReady = 1'b1;
        commitTile();
        waitCommitsDone();
        randomReady = 1'b0;

        // Second box is fully covered, so it wins wherever the two overlap
        testName = "overlapping triangles";
        randomTriangle(t1);
        t1.bbStartX = 4'd1;
        t1.bbStartY = 4'd1;
        t1.bbEndX = 4'd10;
        t1.bbEndY = 4'd10;
        randomTriangle(t2);
        t2.bbStartX = 4'd5;
        t2.bbStartY = 4'd5;
        t2.bbEndX = 4'd14;
        t2.bbEndY = 4'd14;
        t2.w0 = 200;
        t2.w1 = 200;
        t2.w2 = 200;
        t2.color = ~t1.color;
        drawTriangle(t1);
        drawTriangle(t2);
        // The second header waits while the first box is walked one pixel per cycle
        checkEqual("second triangle stalled", 1,
                   headerStall > (t1.bbEndX - t1.bbStartX + 1) * (t1.bbEndY - t1.bbStartY + 1));
        commitTile();
        waitCommitsDone();

        testName = "nop and clear color";
        sendNop();
        sendNop();
        sendNop();
        nextRandom(r);
        setClearColor(r[15:0]);
        commitTile();
        waitCommitsDone();
        clearTile();
        // A NOP passes while the clear is still running
        sendNop();
        checkEqual("nop during clear", 1, lastStall < 8);
        commitTile();
        waitCommitsDone();

        repeat (8) @(negedge aclk);
        checkEqual("pixel stream idle", 0, pixelValid);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/CommandPkg.sv
logic/RasterPkg.sv
logic/CommandParser.sv
logic/RegisterBank.sv
logic/Rasterizer.sv
logic/FrameBuffer.sv
logic/TileRenderer.sv
tests/TileRendererTb.sv

// File: Bender.yml
package:
  name: tile_renderer

sources:
  - include_dirs:
      - logic
    files:
      - logic/CommandPkg.sv
      - logic/RasterPkg.sv
      - logic/CommandParser.sv
      - logic/RegisterBank.sv
      - logic/Rasterizer.sv
      - logic/FrameBuffer.sv
      - logic/TileRenderer.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/TileRendererTb.sv
